/* build.f */
common/ac_pkg.sv
common/pixel_fifo_if.sv
hw/run_control.sv
hw/out_path/pixel_fifo.sv
hw/out_path/beat_streamer.sv
hw/ac_top.sv
verif/tb_ac_top.sv

/* common/ac_pkg.sv */
// Shared geometry, widths and vector types of the access control block.
// Imported by the FIFO, the stream master, the run control and the interface.
package ac_pkg;

	// Pixel and word geometry
	localparam int pixel_bits      = 24;
	localparam int pixels_per_beat = 4;

	// Output image size in pixels
	localparam int dst_width  = 16;
	localparam int dst_height = 4;

	// Derived beat counts
	localparam int beats_per_row   = dst_width / pixels_per_beat;
	localparam int beats_per_frame = beats_per_row * dst_height;

	// Output buffer size in words
	localparam int fifo_depth = 8;

	// One output word holding four packed pixels
	typedef logic [pixel_bits*pixels_per_beat-1:0] beat_t;

	// Wide enough to hold beats_per_frame itself
	typedef logic [$clog2(beats_per_frame+1)-1:0] beat_cnt_t;

	// Register-file data word
	typedef logic [31:0] crf_word_t;

endpackage

/* common/pixel_fifo_if.sv */
// Read side of the output buffer, shared by the FIFO and the stream master.
// The FIFO takes the fifo_side modport, the stream master takes reader.
`timescale 1ns/1ns

interface pixel_fifo_if;
	import ac_pkg::*;

	logic  pop;
	logic  flush;
	logic  empty;
	beat_t rdata;

	modport fifo_side (
		input  pop,
		input  flush,
		output empty,
		output rdata
	);

	modport reader (
		output pop,
		output flush,
		input  empty,
		input  rdata
	);

endinterface

/* hw/ac_top.sv */
// Top level of the access control block of the up-sampling accelerator.
// Takes pixel words from the up-sampler and sends them out as an AXI-Stream
// master, with run control and write-back to the configuration register file.
`timescale 1ns/1ns

module ac_top (
	input  logic             clk,
	input  logic             rst_n,

	// Configuration register file
	input  logic             crf_start,
	input  logic             crf_end,
	output logic             crf_wrt,
	output ac_pkg::crf_word_t crf_wdata,
	output logic             processing,

	// Up-sampler write side
	input  logic             upsp_wvalid,
	input  ac_pkg::beat_t    upsp_wdata,
	output logic             upsp_wready,

	// AXI-Stream master
	output logic             m_axis_tvalid,
	output ac_pkg::beat_t    m_axis_tdata,
	output logic             m_axis_tlast,
	input  logic             m_axis_tready
);

	logic time_window;
	logic frame_done;

	pixel_fifo_if fifo_if ();

	run_control i_run_control (
		.clk         (clk),
		.rst_n       (rst_n),
		.crf_start   (crf_start),
		.crf_end     (crf_end),
		.frame_done  (frame_done),
		.processing  (processing),
		.time_window (time_window),
		.crf_wrt     (crf_wrt),
		.crf_wdata   (crf_wdata)
	);

	pixel_fifo i_pixel_fifo (
		.clk         (clk),
		.rst_n       (rst_n),
		.time_window (time_window),
		.wvalid      (upsp_wvalid),
		.wdata       (upsp_wdata),
		.wready      (upsp_wready),
		.fifo_if     (fifo_if.fifo_side)
	);

	beat_streamer i_beat_streamer (
		.clk         (clk),
		.rst_n       (rst_n),
		.time_window (time_window),
		.tready      (m_axis_tready),
		.tvalid      (m_axis_tvalid),
		.tdata       (m_axis_tdata),
		.tlast       (m_axis_tlast),
		.frame_done  (frame_done),
		.fifo_if     (fifo_if.reader)
	);

endmodule

/* hw/out_path/beat_streamer.sv */
// AXI-Stream master of the access control block.
// Pops the output FIFO, reverses the pixel order of each word, marks row ends
// with tlast and signals the end of the frame when its last beat is taken.
`timescale 1ns/1ns

module beat_streamer (
	input  logic          clk,
	input  logic          rst_n,
	input  logic          time_window,
	input  logic          tready,
	output logic          tvalid,
	output ac_pkg::beat_t tdata,
	output logic          tlast,
	output logic          frame_done,
	pixel_fifo_if.reader  fifo_if
);
	import ac_pkg::*;

	// Beats popped so far in the current frame
	beat_cnt_t beat_cnt;
	logic      frame_full;
	logic      row_end;
	logic      pop;

	assign frame_full = (beat_cnt == beats_per_frame);
	assign row_end    = ((beat_cnt % beats_per_row) == beats_per_row - 1);

	// Pop when the output slot is free or being emptied this cycle
	assign pop = ~fifo_if.empty & time_window & (~tvalid | tready) & ~frame_full;

	assign frame_done    = tvalid & tready & tlast & frame_full;
	assign fifo_if.pop   = pop;
	assign fifo_if.flush = frame_done;

	// Pixel in the top slot goes out in the bottom slot
	always_comb begin
		for (int i = 0; i < pixels_per_beat; i++) begin
			tdata[i*pixel_bits +: pixel_bits] =
				fifo_if.rdata[(pixels_per_beat-1-i)*pixel_bits +: pixel_bits];
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tvalid <= 1'b0;
			tlast  <= 1'b0;
		end else if (pop) begin
			tvalid <= 1'b1;
			tlast  <= row_end;
		end else if (tready) begin
			tvalid <= 1'b0;
			tlast  <= 1'b0;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			beat_cnt <= '0;
		end else if (frame_done) begin
			beat_cnt <= '0;
		end else if (pop) begin
			beat_cnt <= beat_cnt + 1'b1;
		end
	end

endmodule

/* hw/out_path/pixel_fifo.sv */
// Output buffer between the up-sampler and the stream master.
// Circular buffer of fifo_depth words; a pop loads the head word into rdata,
// which then holds until the next pop. Flush drops everything stored.
`timescale 1ns/1ns

module pixel_fifo (
	input  logic          clk,
	input  logic          rst_n,
	input  logic          time_window,
	input  logic          wvalid,
	input  ac_pkg::beat_t wdata,
	output logic          wready,
	pixel_fifo_if.fifo_side fifo_if
);
	import ac_pkg::*;

	beat_t mem [fifo_depth];

	logic [$clog2(fifo_depth)-1:0]   wr_ptr;
	logic [$clog2(fifo_depth)-1:0]   rd_ptr;
	logic [$clog2(fifo_depth+1)-1:0] count;
	logic wr_en;
	logic rd_en;

	assign wready        = (count != fifo_depth);
	assign fifo_if.empty = (count == 0);

	// Words offered outside the window are dropped
	assign wr_en = wvalid & wready & time_window;
	assign rd_en = fifo_if.pop & ~fifo_if.empty;

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_ptr] <= wdata;
		end
		if (rd_en) begin
			fifo_if.rdata <= mem[rd_ptr];
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else if (fifo_if.flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_en) begin
				wr_ptr <= (wr_ptr == fifo_depth - 1) ? '0 : wr_ptr + 1'b1;
			end
			if (rd_en) begin
				rd_ptr <= (rd_ptr == fifo_depth - 1) ? '0 : rd_ptr + 1'b1;
			end
			case ({wr_en, rd_en})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

/* hw/run_control.sv */
// Run control of the access control block.
// Follows the start and end bits of the register file, opens the time window
// for traffic and writes start and end back when a frame is done.
`timescale 1ns/1ns

module run_control (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              crf_start,
	input  logic              crf_end,
	input  logic              frame_done,
	output logic              processing,
	output logic              time_window,
	output logic              crf_wrt,
	output ac_pkg::crf_word_t crf_wdata
);
	import ac_pkg::*;

	logic run_start;
	logic run_stop;
	logic frame_finish;
	logic end_pending;

	// Start is set by software while the block is idle
	assign run_start = crf_start & ~crf_end & ~processing;

	// Software acknowledged the end of the run
	assign run_stop = ~crf_start & crf_end & processing;

	// Last beat of the frame went out during a run
	assign frame_finish = processing & frame_done & crf_start;

	// Start already cleared, end not yet set
	assign end_pending = processing & ~crf_start & ~crf_end;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			processing <= 1'b0;
		end else if (run_start) begin
			processing <= 1'b1;
		end else if (run_stop) begin
			processing <= 1'b0;
		end
	end

	// Traffic is allowed only between start and the end of the frame
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			time_window <= 1'b0;
		end else if (run_start) begin
			time_window <= 1'b1;
		end else if (frame_finish) begin
			time_window <= 1'b0;
		end
	end

	// First write clears start and keeps end, the second one sets end
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			crf_wrt   <= 1'b0;
			crf_wdata <= '0;
		end else if (frame_finish) begin
			crf_wrt   <= 1'b1;
			crf_wdata <= crf_word_t'({crf_end, 1'b0});
		end else if (end_pending) begin
			crf_wrt   <= 1'b1;
			crf_wdata <= crf_word_t'(2'b10);
		end else begin
			crf_wrt   <= 1'b0;
		end
	end

endmodule

/* verif/tb_ac_top.sv */
// Directed testbench for the access control block top level.
// Models the register file, feeds pixel words from the up-sampler side and
// checks the AXI-Stream output, the write-backs and the run flags.
`timescale 1ns/1ns

module tb_ac_top;
	import ac_pkg::*;

	localparam int wait_limit = 2000;

	logic      clk;
	logic      rst_n;
	logic      crf_start;
	logic      crf_end;
	logic      crf_wrt;
	crf_word_t crf_wdata;
	logic      processing;
	logic      upsp_wvalid;
	beat_t     upsp_wdata;
	logic      upsp_wready;
	logic      m_axis_tvalid;
	beat_t     m_axis_tdata;
	logic      m_axis_tlast;
	logic      m_axis_tready;

	// Expected stream words and register-file writes seen so far
	beat_t       exp_data [$];
	crf_word_t   wb_log [$];
	int          beats_seen = 0;
	int          beat_idx = 0;
	logic        ready_random = 1'b0;
	logic        ready_stall = 1'b0;
	// Words accepted when upsp_wready first fell
	int          full_after = -1;
	logic        hold_pending = 1'b0;
	beat_t       held_data;
	logic        held_last;
	logic [31:0] data_state = 32'd74164;
	logic [31:0] ready_state = 32'd74164;

	ac_top i_dut (
		.clk           (clk),
		.rst_n         (rst_n),
		.crf_start     (crf_start),
		.crf_end       (crf_end),
		.crf_wrt       (crf_wrt),
		.crf_wdata     (crf_wdata),
		.processing    (processing),
		.upsp_wvalid   (upsp_wvalid),
		.upsp_wdata    (upsp_wdata),
		.upsp_wready   (upsp_wready),
		.m_axis_tvalid (m_axis_tvalid),
		.m_axis_tdata  (m_axis_tdata),
		.m_axis_tlast  (m_axis_tlast),
		.m_axis_tready (m_axis_tready)
	);

	always #50 clk = ~clk;

	task automatic abort_run();
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic abort_with(input string what);
		$display("Error at %0t ns: %s", $time, what);
		abort_run();
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("FAILED at %0t ns: %s = %b, expected %b", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_beat(input string name, input beat_t got, input beat_t exp);
		if (got !== exp) begin
			$display("FAILED at %0t ns: %s = %h, expected %h", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_crf(input string name, input crf_word_t got, input crf_word_t exp);
		if (got !== exp) begin
			$display("FAILED at %0t ns: %s = %h, expected %h", $time, name, got, exp);
			abort_run();
		end
	endtask

	function automatic logic [31:0] lcg_step(input logic [31:0] state);
		return state * 32'd1103515245 + 32'd12345;
	endfunction

	function automatic beat_t random_word();
		logic [95:0] bits;
		for (int k = 0; k < 3; k++) begin
			data_state = lcg_step(data_state);
			bits[k*32 +: 32] = data_state;
		end
		return beat_t'(bits);
	endfunction

	// Pixel in the top slot of a word is expected in the bottom slot
	function automatic beat_t reverse_pixels(input beat_t word);
		beat_t flipped;
		for (int p = 0; p < pixels_per_beat; p++) begin
			flipped[(pixels_per_beat-1-p)*pixel_bits +: pixel_bits] =
				word[p*pixel_bits +: pixel_bits];
		end
		return flipped;
	endfunction

	// Register file model that loads start from bit 0 and end from bit 1 on a write-back
	always @(negedge clk) begin
		if (rst_n && crf_wrt) begin
			crf_start = crf_wdata[0];
			crf_end   = crf_wdata[1];
			wb_log.push_back(crf_wdata);
		end
	end

	// Stream sink that drives tready and checks each beat the next edge takes
	always @(negedge clk) begin
		if (rst_n) begin
			if (hold_pending) begin
				check_bit("m_axis_tvalid", m_axis_tvalid, 1'b1);
				check_beat("m_axis_tdata", m_axis_tdata, held_data);
				check_bit("m_axis_tlast", m_axis_tlast, held_last);
			end
			ready_state   = lcg_step(ready_state);
			m_axis_tready = ready_stall ? 1'b0 : (ready_random ? ready_state[20] : 1'b1);
			if (m_axis_tvalid && m_axis_tready) begin
				if (exp_data.size() == 0) begin
					abort_with("a beat appeared on the stream with no word expected");
				end
				check_beat("m_axis_tdata", m_axis_tdata, exp_data.pop_front());
				check_bit("m_axis_tlast", m_axis_tlast,
					(beat_idx % beats_per_row) == beats_per_row - 1);
				beat_idx   = (beat_idx == beats_per_frame - 1) ? 0 : beat_idx + 1;
				beats_seen = beats_seen + 1;
			end
			hold_pending = m_axis_tvalid && !m_axis_tready;
			held_data    = m_axis_tdata;
			held_last    = m_axis_tlast;
		end
	end

	// Software sets start and clears end, then the block must start running
	task automatic start_run();
		int waited;
		waited    = 0;
		crf_start = 1'b1;
		crf_end   = 1'b0;
		while (!processing) begin
			@(negedge clk);
			waited++;
			if (waited > wait_limit) abort_with("processing did not rise after start");
		end
	endtask

	task automatic send_frame();
		beat_t word;
		int    waited;
		for (int n = 0; n < beats_per_frame; n++) begin
			word        = random_word();
			upsp_wdata  = word;
			upsp_wvalid = 1'b1;
			waited      = 0;
			while (!upsp_wready) begin
				// Stream is released once the FIFO is full
				if (full_after < 0) full_after = n;
				ready_stall = 1'b0;
				@(negedge clk);
				waited++;
				if (waited > wait_limit) abort_with("upsp_wready stayed low");
			end
			exp_data.push_back(reverse_pixels(word));
			@(negedge clk);
		end
		upsp_wvalid = 1'b0;
	endtask

	task automatic wait_drained();
		int waited;
		waited = 0;
		while (exp_data.size() != 0) begin
			@(negedge clk);
			waited++;
			if (waited > wait_limit) abort_with("written words did not all reach the stream");
		end
	endtask

	// Words offered while the window is closed must never show up
	task automatic offer_dropped_words(input int cycles);
		for (int n = 0; n < cycles; n++) begin
			upsp_wdata  = random_word();
			upsp_wvalid = 1'b1;
			@(negedge clk);
			check_bit("m_axis_tvalid", m_axis_tvalid, 1'b0);
		end
		upsp_wvalid = 1'b0;
		repeat (6) begin
			@(negedge clk);
			check_bit("m_axis_tvalid", m_axis_tvalid, 1'b0);
		end
	endtask

	// Start cleared first, then end set, then the run stops
	task automatic check_frame_end();
		int waited;
		waited = 0;
		while (wb_log.size() < 2 || processing) begin
			@(negedge clk);
			waited++;
			if (waited > wait_limit) abort_with("write-backs or end of run missing");
		end
		if (wb_log.size() != 2) abort_with("more than two write-backs at frame end");
		check_crf("crf_wdata", wb_log[0], 32'd0);
		check_crf("crf_wdata", wb_log[1], 32'd2);
		wb_log.delete();
		check_bit("crf_wrt", crf_wrt, 1'b0);
	endtask

	task automatic test_reset_idle();
		check_bit("processing", processing, 1'b0);
		check_bit("crf_wrt", crf_wrt, 1'b0);
		check_bit("m_axis_tvalid", m_axis_tvalid, 1'b0);
		check_bit("m_axis_tlast", m_axis_tlast, 1'b0);
		offer_dropped_words(12);
		check_bit("processing", processing, 1'b0);
	endtask

	task automatic test_first_frame();
		ready_random = 1'b0;
		start_run();
		send_frame();
		wait_drained();
	endtask

	task automatic test_frame_end();
		check_frame_end();
		offer_dropped_words(10);
	endtask

	task automatic test_backpressure_frame();
		ready_random = 1'b1;
		ready_stall  = 1'b1;
		full_after   = -1;
		start_run();
		send_frame();
		// One word waits in the output slot and the FIFO holds the rest
		if (full_after != fifo_depth + 1) begin
			abort_with("upsp_wready did not fall when the FIFO filled up");
		end
		wait_drained();
		check_frame_end();
		ready_random = 1'b0;
	endtask

	initial begin
		clk           = 1'b0;
		rst_n         = 1'b0;
		crf_start     = 1'b0;
		crf_end       = 1'b0;
		upsp_wvalid   = 1'b0;
		upsp_wdata    = '0;
		m_axis_tready = 1'b0;
		repeat (10) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);

		test_reset_idle();
		test_first_frame();
		test_frame_end();
		test_backpressure_frame();

		if (exp_data.size() != 0 || beats_seen != 2 * beats_per_frame) begin
			$display("Stream carried %0d beats instead of %0d", beats_seen,
				2 * beats_per_frame);
			abort_run();
		end else begin
			$display("Simulation passed");
			$finish;
		end
	end

endmodule
